//--- hdl/branchPredictor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch direction predictor
// Table of two-bit saturating counters, one read per slot
// Trained by retired conditional branches
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module branchPredictor #(
  parameter int bpEntries = 64
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [fetchPkg::pcWidth-1:0]    pc_i,
  input  logic                            updateEn_i,
  input  logic [fetchPkg::pcWidth-1:0]    updatePc_i,
  input  logic                            updateDir_i,
  output logic [fetchPkg::fetchWidth-1:0] predTaken_o
);

  localparam int lowBits = $clog2(fetchPkg::slotBytes);
  localparam int idxBits = $clog2(bpEntries);

  logic [1:0]         counters [bpEntries];
  logic [idxBits-1:0] updIdx;

  assign updIdx = updatePc_i[lowBits +: idxBits];   // Indexed by slot address

  for (genvar k = 0; k < fetchPkg::fetchWidth; k++) begin : gSlot
    logic [fetchPkg::pcWidth-1:0] slotAddr;

    assign slotAddr       = pc_i + fetchPkg::pcWidth'(k * fetchPkg::slotBytes);
    assign predTaken_o[k] = counters[slotAddr[lowBits +: idxBits]][1];   // 2 or 3 is taken
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < bpEntries; i++) begin
        counters[i] <= 2'b01;   // Weakly not taken
      end
    end else if (updateEn_i) begin
      if (updateDir_i && (counters[updIdx] != 2'b11)) begin
        counters[updIdx] <= counters[updIdx] + 2'd1;
      end else if (!updateDir_i && (counters[updIdx] != 2'b00)) begin
        counters[updIdx] <= counters[updIdx] - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/branchTargetBuffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch target buffer
// Direct mapped, one tagged entry per slot position of each set
// Four parallel lookups, one per slot, written by in-order updates
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module branchTargetBuffer #(
  parameter int btbEntries = 16
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic [fetchPkg::pcWidth-1:0]                   pc_i,
  input  logic                                           updateEn_i,
  input  logic [fetchPkg::pcWidth-1:0]                   updatePc_i,
  input  logic [fetchPkg::pcWidth-1:0]                   updateTarget_i,
  input  fetchPkg::brType_t                              updateType_i,
  output logic [fetchPkg::fetchWidth-1:0]                hit_o,
  output fetchPkg::brType_t [fetchPkg::fetchWidth-1:0]   type_o,
  output logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0] target_o
);

  localparam int lowBits = $clog2(fetchPkg::slotBytes);   // Byte offset in a slot
  localparam int idxBits = $clog2(fetchPkg::fetchWidth) + $clog2(btbEntries);
  localparam int tagLo   = lowBits + idxBits;
  localparam int tagBits = fetchPkg::pcWidth - tagLo;
  localparam int depth   = btbEntries * fetchPkg::fetchWidth;

  logic [tagBits-1:0]           tagMem    [depth];
  logic [fetchPkg::pcWidth-1:0] targetMem [depth];
  fetchPkg::brType_t            typeMem   [depth];
  logic [depth-1:0]             validBits;    // One valid bit per entry

  // Flat index is {set, slot position}, the bits just above the byte offset
  logic [idxBits-1:0] updIdx;
  assign updIdx = updatePc_i[lowBits +: idxBits];

  for (genvar k = 0; k < fetchPkg::fetchWidth; k++) begin : gSlot
    logic [fetchPkg::pcWidth-1:0] slotAddr;
    logic [idxBits-1:0]           rdIdx;

    assign slotAddr    = pc_i + fetchPkg::pcWidth'(k * fetchPkg::slotBytes);
    assign rdIdx       = slotAddr[lowBits +: idxBits];
    assign hit_o[k]    = validBits[rdIdx] && (tagMem[rdIdx] == slotAddr[tagLo +: tagBits]);
    assign type_o[k]   = typeMem[rdIdx];
    assign target_o[k] = targetMem[rdIdx];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
    end else if (updateEn_i) begin
      validBits[updIdx] <= 1'b1;
    end
  end

  // Payload side, lookups this cycle still see the old entry
  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      tagMem[updIdx]    <= updatePc_i[tagLo +: tagBits];
      targetMem[updIdx] <= updateTarget_i;
      typeMem[updIdx]   <= updateType_i;
    end
  end

  // A retired control instruction always carries a resolved type
  updateTypeKnown: assert property (@(posedge clk) disable iff (reset)
    updateEn_i |-> !$isunknown(updateType_i));

endmodule

`default_nettype wire

//--- hdl/fetchPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit shared definitions
// Widths of PCs and instructions, bundle geometry, branch type encoding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetchPkg;

  localparam int pcWidth     = 32;  // Every PC and branch target
  localparam int instWidth   = 32;  // One instruction
  localparam int fetchWidth  = 4;   // Slots per bundle
  localparam int bundleWidth = instWidth * fetchWidth;  // Also one cache line

  localparam int slotBytes   = 4;   // Byte step between slots
  localparam int bundleBytes = slotBytes * fetchWidth;  // Sequential bundle step

  // Control instruction type, as carried by the retirement updates
  typedef enum logic [1:0] {
    brReturn = 2'b00,
    brCall   = 2'b01,
    brJump   = 2'b10,
    brCond   = 2'b11
  } brType_t;

endpackage

`default_nettype wire

//--- hdl/fetchStage1.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage one
// Owns the PC, reads cache, target buffer, predictor and return stack,
// and picks the next PC by redirect and slot priority
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module fetchStage1 #(
  parameter int btbEntries = 16,
  parameter int bpEntries  = 64,
  parameter int rasDepth   = 8,
  parameter int cacheLines = 16
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             stall_i,
  input  logic                             recoverFlag_i,
  input  logic [fetchPkg::pcWidth-1:0]     recoverPc_i,
  input  logic                             exceptionFlag_i,
  input  logic [fetchPkg::pcWidth-1:0]     exceptionPc_i,
  input  logic                             flagRecoverEx_i,
  input  logic [fetchPkg::pcWidth-1:0]     targetAddrEx_i,
  input  logic                             flagRecoverId_i,
  input  logic [fetchPkg::pcWidth-1:0]     targetAddrId_i,
  input  logic                             flagRtrId_i,
  input  logic                             updateEn_i,
  input  logic [fetchPkg::pcWidth-1:0]     updatePc_i,
  input  logic [fetchPkg::pcWidth-1:0]     updateTarget_i,
  input  fetchPkg::brType_t                updateType_i,
  input  logic                             updateDir_i,
  input  logic                             wrEnable_i,
  input  logic [fetchPkg::pcWidth-1:0]     wrAddr_i,
  input  logic [fetchPkg::bundleWidth-1:0] instBlock_i,
  output logic [fetchPkg::pcWidth-1:0]     pc_o,
  output logic [fetchPkg::bundleWidth-1:0] bundle_o,
  output logic                             advance_o,
  output logic                             miss_o,
  output logic [fetchPkg::pcWidth-1:0]     missAddr_o
);

  logic [fetchPkg::pcWidth-1:0]    pc;
  logic [fetchPkg::pcWidth-1:0]    nextPc;
  logic [fetchPkg::pcWidth-1:0]    slotTarget;   // Winner among the four slots
  logic [fetchPkg::pcWidth-1:0]    pushAddr;
  logic [fetchPkg::pcWidth-1:0]    rasTop;
  logic [fetchPkg::fetchWidth-1:0] btbHit;
  logic [fetchPkg::fetchWidth-1:0] predTaken;
  logic [fetchPkg::fetchWidth-1:0] takenSlot;
  fetchPkg::brType_t [fetchPkg::fetchWidth-1:0]                 btbType;
  logic [fetchPkg::fetchWidth-1:0][fetchPkg::pcWidth-1:0]       btbTarget;
  logic slotPush, slotPop;
  logic miss, advance, redirect;

  // Predictor learns conditionals only, buffer skips not-taken conditionals
  logic updBpEn, updBtbEn;
  assign updBpEn  = updateEn_i && (updateType_i == fetchPkg::brCond);
  assign updBtbEn = updateEn_i && ((updateType_i != fetchPkg::brCond) || updateDir_i);

  branchTargetBuffer #(.btbEntries(btbEntries)) btb0 (
    .clk(clk), .reset(reset), .pc_i(pc),
    .updateEn_i(updBtbEn), .updatePc_i(updatePc_i),
    .updateTarget_i(updateTarget_i), .updateType_i(updateType_i),
    .hit_o(btbHit), .type_o(btbType), .target_o(btbTarget)
  );

  branchPredictor #(.bpEntries(bpEntries)) bp0 (
    .clk(clk), .reset(reset), .pc_i(pc),
    .updateEn_i(updBpEn), .updatePc_i(updatePc_i), .updateDir_i(updateDir_i),
    .predTaken_o(predTaken)
  );

  returnAddrStack #(.rasDepth(rasDepth)) ras0 (
    .clk(clk), .reset(reset),
    .push_i(slotPush && advance && !redirect), .pushAddr_i(pushAddr),
    .pop_i(slotPop && advance && !redirect), .top_o(rasTop)
  );

  instCache #(.cacheLines(cacheLines)) icache0 (
    .clk(clk), .reset(reset), .addr_i(pc),
    .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i), .instBlock_i(instBlock_i),
    .bundle_o(bundle_o), .miss_o(miss), .missAddr_o(missAddr_o)
  );

  assign advance  = !stall_i && !miss;   // Fresh bundle leaves this cycle
  assign redirect = recoverFlag_i || exceptionFlag_i || flagRecoverEx_i || flagRecoverId_i;

  for (genvar k = 0; k < fetchPkg::fetchWidth; k++) begin : gTaken
    // Unconditional hits are always taken
    assign takenSlot[k] = btbHit[k] && ((btbType[k] != fetchPkg::brCond) || predTaken[k]);
  end

  // Walk slots from last to first so the first taken slot wins
  always_comb begin : slotSelect
    slotTarget = pc + fetchPkg::pcWidth'(fetchPkg::bundleBytes);   // Fall through
    pushAddr   = pc + fetchPkg::pcWidth'(fetchPkg::slotBytes);
    slotPush   = 1'b0;
    slotPop    = 1'b0;
    for (int k = fetchPkg::fetchWidth - 1; k >= 0; k--) begin
      if (takenSlot[k]) begin
        slotTarget = (btbType[k] == fetchPkg::brReturn) ? rasTop : btbTarget[k];
        pushAddr   = pc + fetchPkg::pcWidth'((k + 1) * fetchPkg::slotBytes);  // After call
        slotPush   = (btbType[k] == fetchPkg::brCall);
        slotPop    = (btbType[k] == fetchPkg::brReturn);
      end
    end
  end

  // Later stage recoveries beat any prediction
  always_comb begin : nextPcSelect
    if (flagRecoverEx_i) begin
      nextPc = targetAddrEx_i;
    end else if (flagRecoverId_i) begin
      nextPc = flagRtrId_i ? rasTop : targetAddrId_i;   // Return missed by the buffer
    end else begin
      nextPc = slotTarget;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (recoverFlag_i) begin
      pc <= recoverPc_i;
    end else if (exceptionFlag_i) begin
      pc <= exceptionPc_i;
    end else if (advance || flagRecoverEx_i) begin   // Execute recovery ignores stall
      pc <= nextPc;
    end
  end

  assign pc_o      = pc;
  assign advance_o = advance;
  assign miss_o    = miss;

endmodule

`default_nettype wire

//--- hdl/fetchStage2.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage two
// Fetch to decode pipeline register, holds on stall, flush drops the bundle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module fetchStage2 (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             stall_i,
  input  logic                             flush_i,
  input  logic                             advance_i,
  input  logic [fetchPkg::pcWidth-1:0]     pc_i,
  input  logic [fetchPkg::bundleWidth-1:0] bundle_i,
  output logic                             valid_o,
  output logic [fetchPkg::pcWidth-1:0]     pc_o,
  output logic [fetchPkg::bundleWidth-1:0] bundle_o
);

  always_ff @(posedge clk) begin
    if (reset || flush_i) begin
      valid_o <= 1'b0;   // Flush wins over stall
    end else if (!stall_i) begin
      valid_o <= advance_i;   // Bubble on a miss
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i && !stall_i) begin
      pc_o     <= pc_i;
      bundle_o <= bundle_i;
    end
  end

  validKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(valid_o));

endmodule

`default_nettype wire

//--- hdl/fetchTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fetch unit, first two stages
// Joins the PC stage and the decode register, sets the table sizes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module fetchTop #(
  parameter int btbEntries = 16,
  parameter int bpEntries  = 64,
  parameter int rasDepth   = 8,
  parameter int cacheLines = 16
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             updateEn_i,
  input  logic [fetchPkg::pcWidth-1:0]     updatePc_i,
  input  logic [fetchPkg::pcWidth-1:0]     updateTarget_i,
  input  fetchPkg::brType_t                updateType_i,
  input  logic                             updateDir_i,
  input  logic                             recoverFlag_i,
  input  logic [fetchPkg::pcWidth-1:0]     recoverPc_i,
  input  logic                             exceptionFlag_i,
  input  logic [fetchPkg::pcWidth-1:0]     exceptionPc_i,
  input  logic                             flagRecoverEx_i,
  input  logic [fetchPkg::pcWidth-1:0]     targetAddrEx_i,
  input  logic                             flagRecoverId_i,
  input  logic [fetchPkg::pcWidth-1:0]     targetAddrId_i,
  input  logic                             flagRtrId_i,
  input  logic                             wrEnable_i,
  input  logic [fetchPkg::pcWidth-1:0]     wrAddr_i,
  input  logic [fetchPkg::bundleWidth-1:0] instBlock_i,
  input  logic                             stall_i,
  input  logic                             flush_i,
  output logic                             miss_o,
  output logic [fetchPkg::pcWidth-1:0]     missAddr_o,
  output logic                             bundleValid_o,
  output logic [fetchPkg::pcWidth-1:0]     bundlePc_o,
  output logic [fetchPkg::bundleWidth-1:0] bundle_o
);

  logic [fetchPkg::pcWidth-1:0]     s1Pc;
  logic [fetchPkg::bundleWidth-1:0] s1Bundle;
  logic                             s1Advance;
  logic                             s2Flush;

  // Any redirect makes the bundle in flight wrong path
  assign s2Flush = flush_i || recoverFlag_i || exceptionFlag_i || flagRecoverEx_i
                   || flagRecoverId_i;

  fetchStage1 #(
    .btbEntries(btbEntries), .bpEntries(bpEntries),
    .rasDepth(rasDepth), .cacheLines(cacheLines)
  ) stage1 (
    .clk(clk), .reset(reset), .stall_i(stall_i),
    .recoverFlag_i(recoverFlag_i), .recoverPc_i(recoverPc_i),
    .exceptionFlag_i(exceptionFlag_i), .exceptionPc_i(exceptionPc_i),
    .flagRecoverEx_i(flagRecoverEx_i), .targetAddrEx_i(targetAddrEx_i),
    .flagRecoverId_i(flagRecoverId_i), .targetAddrId_i(targetAddrId_i),
    .flagRtrId_i(flagRtrId_i),
    .updateEn_i(updateEn_i), .updatePc_i(updatePc_i), .updateTarget_i(updateTarget_i),
    .updateType_i(updateType_i), .updateDir_i(updateDir_i),
    .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i), .instBlock_i(instBlock_i),
    .pc_o(s1Pc), .bundle_o(s1Bundle), .advance_o(s1Advance),
    .miss_o(miss_o), .missAddr_o(missAddr_o)
  );

  fetchStage2 stage2 (
    .clk(clk), .reset(reset), .stall_i(stall_i), .flush_i(s2Flush),
    .advance_i(s1Advance), .pc_i(s1Pc), .bundle_i(s1Bundle),
    .valid_o(bundleValid_o), .pc_o(bundlePc_o), .bundle_o(bundle_o)
  );

endmodule

`default_nettype wire

//--- hdl/instCache.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Level one instruction cache
// Direct mapped, one bundle per line, combinational read
// Misses report the line address, refills come from lower memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module instCache #(
  parameter int cacheLines = 16
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [fetchPkg::pcWidth-1:0]     addr_i,
  input  logic                             wrEnable_i,
  input  logic [fetchPkg::pcWidth-1:0]     wrAddr_i,
  input  logic [fetchPkg::bundleWidth-1:0] instBlock_i,
  output logic [fetchPkg::bundleWidth-1:0] bundle_o,
  output logic                             miss_o,
  output logic [fetchPkg::pcWidth-1:0]     missAddr_o
);

  localparam int offBits = $clog2(fetchPkg::bundleBytes);
  localparam int idxBits = $clog2(cacheLines);
  localparam int tagBits = fetchPkg::pcWidth - offBits - idxBits;

  logic [fetchPkg::bundleWidth-1:0] dataMem [cacheLines];
  logic [tagBits-1:0]               tagMem  [cacheLines];
  logic [cacheLines-1:0]            validBits;

  logic [idxBits-1:0] rdIdx;
  logic [idxBits-1:0] wrIdx;

  assign rdIdx = addr_i[offBits +: idxBits];
  assign wrIdx = wrAddr_i[offBits +: idxBits];

  // Lookup in the same cycle as the PC
  assign bundle_o   = dataMem[rdIdx];
  assign miss_o     = !(validBits[rdIdx] && (tagMem[rdIdx] == addr_i[offBits + idxBits +: tagBits]));
  assign missAddr_o = {addr_i[fetchPkg::pcWidth-1:offBits], {offBits{1'b0}}};   // Line aligned

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;   // Cold cache, first fetch misses
    end else if (wrEnable_i) begin
      validBits[wrIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      dataMem[wrIdx] <= instBlock_i;
      tagMem[wrIdx]  <= wrAddr_i[offBits + idxBits +: tagBits];
    end
  end

endmodule

`default_nettype wire

//--- hdl/returnAddrStack.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Return address stack
// Circular stack with a top pointer, push on calls and pop on returns
// Overflow silently overwrites the oldest entry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module returnAddrStack #(
  parameter int rasDepth = 8    // Power of two, the pointer wraps
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push_i,
  input  logic [fetchPkg::pcWidth-1:0] pushAddr_i,
  input  logic                         pop_i,
  output logic [fetchPkg::pcWidth-1:0] top_o
);

  localparam int ptrBits = $clog2(rasDepth);

  logic [fetchPkg::pcWidth-1:0] stackMem [rasDepth];
  logic [ptrBits-1:0]           topPtr;
  logic [ptrBits-1:0]           abovePtr;

  assign abovePtr = topPtr + 1'b1;   // Wraps onto the oldest entry when full
  assign top_o    = stackMem[topPtr];

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
    end else if (push_i) begin
      topPtr <= abovePtr;
    end else if (pop_i) begin
      topPtr <= topPtr - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      stackMem[abovePtr] <= pushAddr_i;
    end
  end

  // Only the first taken slot drives these, so one bundle never does both
  noPushPop: assert property (@(posedge clk) disable iff (reset)
    !(push_i && pop_i));

endmodule

`default_nettype wire

//--- list.f
hdl/fetchPkg.sv
hdl/branchTargetBuffer.sv
hdl/branchPredictor.sv
hdl/returnAddrStack.sv
hdl/instCache.sv
hdl/fetchStage1.sv
hdl/fetchStage2.sv
hdl/fetchTop.sv
tb/fetchTb.sv

//--- run.sh
#!/bin/sh
# Builds the fetch unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetchTb -Mdir obj_dir -f list.f

./obj_dir/VfetchTb | tee sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation completed successfully" sim.log; then
  exit 1
fi
exit 0

//--- tb/fetchTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit testbench
// Replays a command file of refills, branch updates, redirects and
// expected bundles, with random stall cycles from an LFSR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ns

module fetchTb;

  localparam int stimWords = 256;   // Four words per command
  localparam int maxWait   = 100;   // Cycles allowed per wait loop
  localparam logic [31:0] fillKey = 32'hc0de_0000;

  logic clk;
  logic reset;
  logic updateEn_i, updateDir_i;
  logic [fetchPkg::pcWidth-1:0] updatePc_i, updateTarget_i;
  fetchPkg::brType_t updateType_i;
  logic recoverFlag_i, exceptionFlag_i, flagRecoverEx_i, flagRecoverId_i, flagRtrId_i;
  logic [fetchPkg::pcWidth-1:0] recoverPc_i, exceptionPc_i, targetAddrEx_i, targetAddrId_i;
  logic wrEnable_i;
  logic [fetchPkg::pcWidth-1:0] wrAddr_i;
  logic [fetchPkg::bundleWidth-1:0] instBlock_i;
  logic stall_i, flush_i;
  logic miss_o, bundleValid_o;
  logic [fetchPkg::pcWidth-1:0] missAddr_o, bundlePc_o;
  logic [fetchPkg::bundleWidth-1:0] bundle_o;

  logic [31:0] stim [stimWords];
  logic [31:0] lfsr;
  logic timedOut;
  int errorCount, checkCount, testCount, testErrors, testChecks;

  fetchTop #(
    .btbEntries(16), .bpEntries(64), .rasDepth(8), .cacheLines(16)
  ) dut0 (
    .clk(clk), .reset(reset),
    .updateEn_i(updateEn_i), .updatePc_i(updatePc_i), .updateTarget_i(updateTarget_i),
    .updateType_i(updateType_i), .updateDir_i(updateDir_i),
    .recoverFlag_i(recoverFlag_i), .recoverPc_i(recoverPc_i),
    .exceptionFlag_i(exceptionFlag_i), .exceptionPc_i(exceptionPc_i),
    .flagRecoverEx_i(flagRecoverEx_i), .targetAddrEx_i(targetAddrEx_i),
    .flagRecoverId_i(flagRecoverId_i), .targetAddrId_i(targetAddrId_i),
    .flagRtrId_i(flagRtrId_i),
    .wrEnable_i(wrEnable_i), .wrAddr_i(wrAddr_i), .instBlock_i(instBlock_i),
    .stall_i(stall_i), .flush_i(flush_i),
    .miss_o(miss_o), .missAddr_o(missAddr_o),
    .bundleValid_o(bundleValid_o), .bundlePc_o(bundlePc_o), .bundle_o(bundle_o)
  );

  always #20 clk = ~clk;   // 40 ns period

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Instruction word held at a byte address of lower memory
  function automatic logic [31:0] instAt(input logic [31:0] addr);
    return addr ^ fillKey;
  endfunction

  // Whole cache line around an address, slot 0 in the low word
  function automatic logic [fetchPkg::bundleWidth-1:0] lineAt(input logic [31:0] addr);
    logic [fetchPkg::bundleWidth-1:0] line;
    logic [31:0] base;
    base = {addr[31:4], 4'h0};
    for (int k = 0; k < fetchPkg::fetchWidth; k++) begin
      line[k*32 +: 32] = instAt(base + 32'(k * fetchPkg::slotBytes));
    end
    return line;
  endfunction

  task automatic checkValue(input string what, input logic [127:0] actual,
                            input logic [127:0] expected);
    checkCount++;
    testChecks++;
    if (actual !== expected) begin
      errorCount++;
      testErrors++;
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Two bits per decision, so about one cycle in four stalls
  task automatic randomStall();
    logic b0;
    lfsr = lfsrNext(lfsr);
    b0 = lfsr[0];
    lfsr = lfsrNext(lfsr);
    stall_i = b0 & lfsr[0];
  endtask

  task automatic refillLines(input logic [31:0] base, input int count);
    for (int i = 0; i < count; i++) begin
      wrEnable_i  = 1'b1;
      wrAddr_i    = base + 32'(i * fetchPkg::bundleBytes);
      instBlock_i = lineAt(wrAddr_i);
      @(negedge clk);
    end
    wrEnable_i = 1'b0;
  endtask

  // code holds the branch type in bits 5:4 and the direction in bit 0
  task automatic applyUpdate(input logic [31:0] pc, input logic [31:0] target,
                             input logic [31:0] code);
    updateEn_i     = 1'b1;
    updatePc_i     = pc;
    updateTarget_i = target;
    updateType_i   = fetchPkg::brType_t'(code[5:4]);
    updateDir_i    = code[0];
    @(negedge clk);
    updateEn_i = 1'b0;
  endtask

  // kind bits: 0 recover, 1 exception, 2 execute, 3 decode, 4 decode return
  task automatic applyRedirect(input logic [31:0] kind, input logic [31:0] pcA,
                               input logic [31:0] pcB);
    recoverFlag_i   = kind[0];
    exceptionFlag_i = kind[1];
    flagRecoverEx_i = kind[2];
    flagRecoverId_i = kind[3];
    flagRtrId_i     = kind[4];
    recoverPc_i     = pcA;
    targetAddrEx_i  = pcA;
    targetAddrId_i  = pcA;
    exceptionPc_i   = pcB;
    stall_i         = !kind[3];   // Decode recovery only lands when stage one advances
    @(negedge clk);
    checkValue("bundleValid_o", 128'(bundleValid_o), 128'(0));   // Wrong path bundle dropped
    recoverFlag_i   = 1'b0;
    exceptionFlag_i = 1'b0;
    flagRecoverEx_i = 1'b0;
    flagRecoverId_i = 1'b0;
    flagRtrId_i     = 1'b0;
    stall_i         = 1'b1;
  endtask

  task automatic expectMiss(input logic [31:0] addr);
    int n;
    n = 0;
    while (!miss_o && n < maxWait) begin
      @(negedge clk);
      n++;
    end
    if (!miss_o) begin
      $display("Timeout: miss_o never rose after reset");
      timedOut = 1'b1;
    end else begin
      checkValue("missAddr_o", 128'(missAddr_o), 128'(addr));
      checkValue("bundleValid_o", 128'(bundleValid_o), 128'(0));
    end
  endtask

  // Lets exactly one fresh bundle into stage two, then parks the pipe
  task automatic expectBundle(input logic [31:0] pc, input logic [31:0] firstInst);
    int n;
    logic fresh;
    n = 0;
    fresh = 1'b0;
    randomStall();
    while (!fresh && n < maxWait) begin
      @(negedge clk);
      fresh = bundleValid_o && !stall_i;   // Stage two loaded at the edge just passed
      if (!fresh) begin
        randomStall();
      end
      n++;
    end
    if (fresh) begin
      checkValue("bundlePc_o", 128'(bundlePc_o), 128'(pc));
      checkValue("bundle_o[31:0]", 128'(bundle_o[31:0]), 128'(firstInst));
      checkValue("bundle_o", bundle_o, lineAt(pc));
    end else begin
      $display("Timeout: no bundle at PC %0h within %0d cycles", pc, maxWait);
      timedOut = 1'b1;
    end
    stall_i = 1'b1;
  endtask

  initial begin
    int ip;
    logic [31:0] op, a, b, c;
    clk             = 1'b0;
    reset           = 1'b1;
    stall_i         = 1'b1;   // Fetch only runs while a bundle is expected
    flush_i         = 1'b0;
    updateEn_i      = 1'b0;
    updateDir_i     = 1'b0;
    updatePc_i      = '0;
    updateTarget_i  = '0;
    updateType_i    = fetchPkg::brJump;
    recoverFlag_i   = 1'b0;
    exceptionFlag_i = 1'b0;
    flagRecoverEx_i = 1'b0;
    flagRecoverId_i = 1'b0;
    flagRtrId_i     = 1'b0;
    recoverPc_i     = '0;
    exceptionPc_i   = '0;
    targetAddrEx_i  = '0;
    targetAddrId_i  = '0;
    wrEnable_i      = 1'b0;
    wrAddr_i        = '0;
    instBlock_i     = '0;
    lfsr            = 32'hc4ea_7aa7;
    timedOut        = 1'b0;
    errorCount      = 0;
    checkCount      = 0;
    testCount       = 0;
    testErrors      = 0;
    testChecks      = 0;
    for (int i = 0; i < stimWords; i++) begin
      stim[i] = '0;   // Zero op ends the command list
    end
    $readmemh("tb/fetch_stimulus.txt", stim);
    repeat (16) @(negedge clk);
    reset = 1'b0;
    ip = 0;
    while (ip < stimWords && stim[ip] != 0 && !timedOut) begin
      op = stim[ip];
      a  = stim[ip+1];
      b  = stim[ip+2];
      c  = stim[ip+3];
      case (op)
        1: refillLines(a, int'(b));
        2: applyUpdate(a, b, c);
        3: applyRedirect(a, b, c);
        4: expectBundle(a, b);
        5: begin
          testCount++;
          $display("Test %0d done: %0d checks, %0d errors", a, testChecks, testErrors);
          testChecks = 0;
          testErrors = 0;
        end
        6: repeat (a) @(negedge clk);   // Idle with the pipe parked
        7: expectMiss(a);
        default: begin
          $display("Unknown command %0h at stimulus word %0d", op, ip);
          errorCount++;
        end
      endcase
      ip += 4;
    end
    if (checkCount == 0) begin
      $display("No checks ran, the stimulus file is empty or missing");
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
    if (errorCount == 0 && !timedOut && checkCount > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/fetch_stimulus.txt
// Columns: op a b c, all hex. 1 refill a lines from b count, 2 update pc a target b
// type/dir c, 3 redirect flags a pc b exception pc c, 4 expect pc a first inst b,
// 5 end of test a, 6 idle a cycles, 7 expect miss at a, 0 stop
7 00000000 0 0
1 00000000 10 0
4 00000000 c0de0000 0
4 00000010 c0de0010 0
4 00000020 c0de0020 0
4 00000030 c0de0030 0
5 1 0 0
2 00000058 000000a0 21
6 4 0 0
4 00000040 c0de0040 0
4 00000050 c0de0050 0
4 000000a0 c0de00a0 0
5 2 0 0
2 000000dc 000000c0 21
2 000000c4 000000b0 30
2 000000c4 000000b0 31
4 000000b0 c0de00b0 0
4 000000c0 c0de00c0 0
4 000000d0 c0de00d0 0
2 000000c4 000000b0 31
4 000000c0 c0de00c0 0
2 000000c4 000000b0 30
2 000000c4 000000b0 30
4 000000b0 c0de00b0 0
4 000000c0 c0de00c0 0
5 3 0 0
2 00000064 00000080 11
2 00000084 000000e0 11
2 000000e0 00000000 01
2 0000008c 00000000 01
3 02 00000000 00000060
4 00000060 c0de0060 0
4 00000080 c0de0080 0
4 000000e0 c0de00e0 0
4 00000088 c0de0080 0
4 00000068 c0de0060 0
5 4 0 0
3 03 00000020 00000090
4 00000020 c0de0020 0
3 02 00000000 00000040
4 00000040 c0de0040 0
5 5 0 0
3 04 00000080 0
4 00000080 c0de0080 0
3 08 00000030 0
4 00000030 c0de0030 0
3 18 00000020 0
4 00000088 c0de0080 0
5 6 0 0
0 0 0 0
